/* src/console_ctrl_pkg.sv */
package console_ctrl_pkg;

    localparam int COUNT_WIDTH = 32;
    localparam int RSP_WIDTH   = 8;

    ////////////////////////////////////////////////////////////
    // opcodes

    localparam logic [3:0] OP_CONSOLE_RESET = 4'd1;
    localparam logic [3:0] OP_OPT_RESET     = 4'd2;
    localparam logic [3:0] OP_SET_LED_MODE  = 4'd3;
    localparam logic [3:0] OP_READ_COUNTER  = 4'd4;

    // status led sources
    // value 3 shows the optional board reset
    localparam logic [1:0] LED_INDICATOR     = 2'd0;
    localparam logic [1:0] LED_OPT_RESET     = 2'd1;
    localparam logic [1:0] LED_CONSOLE_RESET = 2'd2;

    // event counters
    // select 3 reads zero
    localparam logic [1:0] CNT_PLL54    = 2'd0;
    localparam logic [1:0] CNT_PLL_HDMI = 2'd1;
    localparam logic [1:0] CNT_RESYNC   = 2'd2;

    localparam logic [RSP_WIDTH-1:0] RSP_UNKNOWN = 8'd255;

    ////////////////////////////////////////////////////////////
    // command word

    // opcode nibble on top in both views
    typedef union packed {
        struct packed {
            logic [3:0] opcode;
            logic [1:0] led_mode;
            logic [9:0] unused;
        } ctrl;
        struct packed {
            logic [3:0] opcode;
            logic [1:0] counter_sel;
            logic [1:0] byte_sel;
            logic [7:0] unused;
        } rd;
    } cmd_word_u;

endpackage

/* src/led_glow.sv */
module led_glow #(
    parameter int GLOW_BIT = 26
) (
    input  logic control_clock,
    input  logic reset_dc,
    output logic glow
);

    localparam int LEVEL_W = 4;

    logic [GLOW_BIT:0]  count;
    logic [LEVEL_W-1:0] level;

    // brightness ramps up while the top bit is set, then back down
    assign level = count[GLOW_BIT] ? count[GLOW_BIT-1 -: LEVEL_W]
                                   : ~count[GLOW_BIT-1 -: LEVEL_W];

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            count <= '0;
            glow  <= 1'b0;
        end else begin
            count <= count + (GLOW_BIT + 1)'(1);
            // pwm against the fast bottom bits
            glow  <= level > count[LEVEL_W-1:0];
        end
    end

endmodule

/* src/command_decode.sv */
module command_decode
    import console_ctrl_pkg::*;
(
    input  logic       control_clock,
    input  logic       reset_dc,
    input  logic       cmd_req,
    input  cmd_word_u  cmd_word,
    input  logic       done,
    output logic       exec_strobe,
    output logic [3:0] opcode,
    output logic [1:0] led_mode,
    output logic [1:0] counter_sel,
    output logic [1:0] byte_sel
);

    logic      req_q;
    logic      busy;
    logic      done_seen;
    logic      idle;
    logic      accept;
    cmd_word_u word_q;

    // free again once the last acknowledge has risen and dropped
    assign idle   = !busy || (done_seen && !done);
    assign accept = idle && cmd_req && !req_q;

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            req_q       <= 1'b0;
            busy        <= 1'b0;
            done_seen   <= 1'b0;
            exec_strobe <= 1'b0;
        end else begin
            req_q       <= cmd_req;
            exec_strobe <= accept;
            if (accept) begin
                busy      <= 1'b1;
                done_seen <= 1'b0;
            end else if (idle) begin
                busy <= 1'b0;
            end else if (done) begin
                done_seen <= 1'b1;
            end
        end
    end

    // word is only sampled on an accepted request edge
    always_ff @(posedge control_clock) begin
        if (accept) begin
            word_q <= cmd_word;
        end
    end

    ////////////////////////////////////////////////////////////
    // field decode

    // control view
    assign opcode   = word_q.ctrl.opcode;
    assign led_mode = word_q.ctrl.led_mode;

    // read view
    assign counter_sel = word_q.rd.counter_sel;
    assign byte_sel    = word_q.rd.byte_sel;

endmodule

/* src/reset_execute.sv */
module reset_execute
    import console_ctrl_pkg::*;
#(
    parameter logic [31:0] HOLD_CYCLES = 32'd32_000_000
) (
    input  logic       control_clock,
    input  logic       reset_dc,
    input  logic       exec_strobe,
    input  logic [3:0] opcode,
    input  logic [1:0] led_mode,
    output logic [1:0] led_mode_reg,
    output logic       console_nreset,
    output logic       opt_nreset
);

    localparam int LINES = 2;

    // line 0 is the console, line 1 the optional board
    localparam logic [LINES-1:0][3:0] LINE_OPS = {OP_OPT_RESET, OP_CONSOLE_RESET};

    wire [LINES-1:0] line_n;

    ////////////////////////////////////////////////////////////
    // reset hold timers

    for (genvar i = 0; i < LINES; i++) begin : g_line
        logic [31:0] hold_count;
        logic        nreset_q;
        logic        start;

        assign start = exec_strobe && (opcode == LINE_OPS[i]);

        // a new command restarts the hold even while already low
        always_ff @(posedge control_clock) begin
            if (reset_dc) begin
                hold_count <= '0;
                nreset_q   <= 1'b1;
            end else if (start) begin
                hold_count <= '0;
                nreset_q   <= 1'b0;
            end else if (!nreset_q) begin
                hold_count <= hold_count + 32'd1;
                if (hold_count == HOLD_CYCLES) begin
                    nreset_q <= 1'b1;
                end
            end
        end

        assign line_n[i] = nreset_q;
    end

    assign console_nreset = line_n[0];
    assign opt_nreset     = line_n[1];

    ////////////////////////////////////////////////////////////
    // led mode

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            led_mode_reg <= LED_INDICATOR;
        end else if (exec_strobe && (opcode == OP_SET_LED_MODE)) begin
            led_mode_reg <= led_mode;
        end
    end

endmodule

/* src/event_counters.sv */
module event_counters
    import console_ctrl_pkg::*;
(
    input  logic                   control_clock,
    input  logic                   reset_dc,
    input  logic                   pll54_locked,
    input  logic                   pll_hdmi_locked,
    input  logic                   resync,
    output logic [COUNT_WIDTH-1:0] pll54_loss_count,
    output logic [COUNT_WIDTH-1:0] pll_hdmi_loss_count,
    output logic [COUNT_WIDTH-1:0] resync_count
);

    localparam int EVENTS = 3;

    logic [EVENTS-1:0]      event_lvl;
    logic [EVENTS-1:0]      event_prev;
    logic [COUNT_WIDTH-1:0] count [EVENTS];

    // lock loss is a rising edge of the inverted lock
    assign event_lvl = {resync, ~pll_hdmi_locked, ~pll54_locked};

    // levels one cycle back for edge detection
    always_ff @(posedge control_clock) begin
        event_prev <= event_lvl;
    end

    ////////////////////////////////////////////////////////////
    // counters

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            for (int i = 0; i < EVENTS; i++) begin
                count[i] <= '0;
            end
        end else begin
            for (int i = 0; i < EVENTS; i++) begin
                if (event_lvl[i] && !event_prev[i]) begin
                    count[i] <= count[i] + COUNT_WIDTH'(1);
                end
            end
        end
    end

    assign pll54_loss_count    = count[0];
    assign pll_hdmi_loss_count = count[1];
    assign resync_count        = count[2];

endmodule

/* src/status_result.sv */
module status_result
    import console_ctrl_pkg::*;
#(
    parameter int SLOW_GLOW_BIT = 26,
    parameter int FAST_GLOW_BIT = 22,
    parameter int BLINK_BIT     = 24
) (
    input  logic                   control_clock,
    input  logic                   reset_dc,
    input  logic                   exec_strobe,
    input  logic [3:0]             opcode,
    input  logic [1:0]             counter_sel,
    input  logic [1:0]             byte_sel,
    input  logic [1:0]             led_mode_reg,
    input  logic                   console_nreset,
    input  logic                   opt_nreset,
    input  logic [COUNT_WIDTH-1:0] pll54_loss_count,
    input  logic [COUNT_WIDTH-1:0] pll_hdmi_loss_count,
    input  logic [COUNT_WIDTH-1:0] resync_count,
    input  logic                   pll_hdmi_locked,
    input  logic                   resync,
    input  logic                   force_generate,
    input  logic                   hdmi_ready,
    input  logic                   cmd_req,
    output logic                   status_led,
    output logic                   cmd_ack,
    output logic [RSP_WIDTH-1:0]   rsp_data,
    output logic                   done
);

    logic                   slow_glow;
    logic                   fast_glow;
    logic [BLINK_BIT:0]     blink_count;
    logic                   led_next;
    logic [COUNT_WIDTH-1:0] sel_count;
    logic [RSP_WIDTH-1:0]   rsp_next;
    logic                   ack_q;

    led_glow #(.GLOW_BIT(SLOW_GLOW_BIT)) slow_glow_gen (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .glow          (slow_glow)
    );

    led_glow #(.GLOW_BIT(FAST_GLOW_BIT)) fast_glow_gen (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .glow          (fast_glow)
    );

    ////////////////////////////////////////////////////////////
    // status led

    // led is active low
    always_comb begin
        case (led_mode_reg)
            LED_CONSOLE_RESET: led_next = console_nreset;
            LED_INDICATOR: begin
                if (!pll_hdmi_locked) begin
                    led_next = 1'b1;
                end else if (resync) begin
                    led_next = ~fast_glow;
                end else if (force_generate) begin
                    led_next = blink_count[BLINK_BIT] ? ~fast_glow : 1'b1;
                end else if (hdmi_ready) begin
                    led_next = 1'b0;
                end else begin
                    led_next = ~slow_glow;
                end
            end
            default: led_next = opt_nreset;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // response

    always_comb begin
        case (counter_sel)
            CNT_PLL54:    sel_count = pll54_loss_count;
            CNT_PLL_HDMI: sel_count = pll_hdmi_loss_count;
            CNT_RESYNC:   sel_count = resync_count;
            default:      sel_count = '0;
        endcase
    end

    always_comb begin
        case (opcode)
            OP_READ_COUNTER:  rsp_next = sel_count[RSP_WIDTH * byte_sel +: RSP_WIDTH];
            OP_CONSOLE_RESET: rsp_next = '0;
            OP_OPT_RESET:     rsp_next = '0;
            OP_SET_LED_MODE:  rsp_next = '0;
            default:          rsp_next = RSP_UNKNOWN;
        endcase
    end

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            blink_count <= '0;
            status_led  <= 1'b1;
            ack_q       <= 1'b0;
        end else begin
            blink_count <= blink_count + (BLINK_BIT + 1)'(1);
            status_led  <= led_next;
            if (exec_strobe) begin
                ack_q <= 1'b1;
            end else if (ack_q && !cmd_req) begin
                ack_q <= 1'b0;
            end
        end
    end

    // held until the next acknowledge
    always_ff @(posedge control_clock) begin
        if (exec_strobe) begin
            rsp_data <= rsp_next;
        end
    end

    assign cmd_ack = ack_q;
    assign done    = ack_q;

endmodule

/* src/console_ctrl_top.sv */
module console_ctrl_top
    import console_ctrl_pkg::*;
#(
    parameter logic [31:0] HOLD_CYCLES   = 32'd32_000_000,
    parameter int          SLOW_GLOW_BIT = 26,
    parameter int          FAST_GLOW_BIT = 22,
    parameter int          BLINK_BIT     = 24
) (
    input  logic                 control_clock,
    input  logic                 reset_dc,
    input  logic                 cmd_req,
    input  cmd_word_u            cmd_word,
    output logic                 cmd_ack,
    output logic [RSP_WIDTH-1:0] rsp_data,
    input  logic                 pll54_locked,
    input  logic                 pll_hdmi_locked,
    input  logic                 resync,
    input  logic                 force_generate,
    input  logic                 hdmi_ready,
    output logic                 console_nreset,
    output logic                 opt_nreset,
    output logic                 status_led
);

    logic                   exec_strobe;
    logic                   done;
    logic [3:0]             opcode;
    logic [1:0]             led_mode;
    logic [1:0]             counter_sel;
    logic [1:0]             byte_sel;
    logic [1:0]             led_mode_reg;
    logic [COUNT_WIDTH-1:0] pll54_loss_count;
    logic [COUNT_WIDTH-1:0] pll_hdmi_loss_count;
    logic [COUNT_WIDTH-1:0] resync_count;

    ////////////////////////////////////////////////////////////
    // decode

    command_decode u_decode (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .cmd_req       (cmd_req),
        .cmd_word      (cmd_word),
        .done          (done),
        .exec_strobe   (exec_strobe),
        .opcode        (opcode),
        .led_mode      (led_mode),
        .counter_sel   (counter_sel),
        .byte_sel      (byte_sel)
    );

    ////////////////////////////////////////////////////////////
    // execute

    reset_execute #(.HOLD_CYCLES(HOLD_CYCLES)) u_reset (
        .control_clock  (control_clock),
        .reset_dc       (reset_dc),
        .exec_strobe    (exec_strobe),
        .opcode         (opcode),
        .led_mode       (led_mode),
        .led_mode_reg   (led_mode_reg),
        .console_nreset (console_nreset),
        .opt_nreset     (opt_nreset)
    );

    event_counters u_counters (
        .control_clock       (control_clock),
        .reset_dc            (reset_dc),
        .pll54_locked        (pll54_locked),
        .pll_hdmi_locked     (pll_hdmi_locked),
        .resync              (resync),
        .pll54_loss_count    (pll54_loss_count),
        .pll_hdmi_loss_count (pll_hdmi_loss_count),
        .resync_count        (resync_count)
    );

    ////////////////////////////////////////////////////////////
    // result

    status_result #(
        .SLOW_GLOW_BIT (SLOW_GLOW_BIT),
        .FAST_GLOW_BIT (FAST_GLOW_BIT),
        .BLINK_BIT     (BLINK_BIT)
    ) u_result (
        .control_clock       (control_clock),
        .reset_dc            (reset_dc),
        .exec_strobe         (exec_strobe),
        .opcode              (opcode),
        .counter_sel         (counter_sel),
        .byte_sel            (byte_sel),
        .led_mode_reg        (led_mode_reg),
        .console_nreset      (console_nreset),
        .opt_nreset          (opt_nreset),
        .pll54_loss_count    (pll54_loss_count),
        .pll_hdmi_loss_count (pll_hdmi_loss_count),
        .resync_count        (resync_count),
        .pll_hdmi_locked     (pll_hdmi_locked),
        .resync              (resync),
        .force_generate      (force_generate),
        .hdmi_ready          (hdmi_ready),
        .cmd_req             (cmd_req),
        .status_led          (status_led),
        .cmd_ack             (cmd_ack),
        .rsp_data            (rsp_data),
        .done                (done)
    );

endmodule

/* testbench/console_ctrl_tb.sv */
module console_ctrl_tb
    import console_ctrl_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] HOLD_CYCLES = 32'd20;
    localparam int          MAX_TESTS   = 64;
    localparam int          TEST_NS     = 2000;

    // columns of the test file
    localparam int F_CODE   = 0;
    localparam int F_WORD   = 1;
    localparam int F_LK54   = 2;
    localparam int F_LKHD   = 3;
    localparam int F_RESYNC = 4;
    localparam int F_FORCE  = 5;
    localparam int F_READY  = 6;
    localparam int F_PULSES = 7;
    localparam int F_RSP    = 8;
    localparam int F_LED    = 9;

    logic                 control_clock;
    logic                 reset_dc;
    logic                 cmd_req;
    cmd_word_u            cmd_word;
    logic                 cmd_ack;
    logic [RSP_WIDTH-1:0] rsp_data;
    logic                 pll54_locked;
    logic                 pll_hdmi_locked;
    logic                 resync;
    logic                 force_generate;
    logic                 hdmi_ready;
    logic                 console_nreset;
    logic                 opt_nreset;
    logic                 status_led;

    int         tests [MAX_TESTS][10];
    int         n_tests;
    int         mismatches;
    int         failed_tests;
    bit         loaded;
    bit         test_ok;
    logic [1:0] led_mode;

    console_ctrl_top #(
        .HOLD_CYCLES   (HOLD_CYCLES),
        .SLOW_GLOW_BIT (6),
        .FAST_GLOW_BIT (4),
        .BLINK_BIT     (5)
    ) DUT (
        .control_clock   (control_clock),
        .reset_dc        (reset_dc),
        .cmd_req         (cmd_req),
        .cmd_word        (cmd_word),
        .cmd_ack         (cmd_ack),
        .rsp_data        (rsp_data),
        .pll54_locked    (pll54_locked),
        .pll_hdmi_locked (pll_hdmi_locked),
        .resync          (resync),
        .force_generate  (force_generate),
        .hdmi_ready      (hdmi_ready),
        .console_nreset  (console_nreset),
        .opt_nreset      (opt_nreset),
        .status_led      (status_led)
    );

    initial begin
        control_clock = 1'b0;
        forever #5 control_clock = ~control_clock;
    end

    initial begin
        wait (loaded);
        #(n_tests * TEST_NS + 100);
        $display("watchdog expired, the DUT stopped answering the host handshake");
        $display("Result: FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // helpers

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0d ns %s: got %0h, expected %0h", $time, name, got, exp);
            mismatches++;
            test_ok = 1'b0;
        end
    endtask

    function automatic logic line_level(input bit console);
        return console ? console_nreset : opt_nreset;
    endfunction

    task automatic load_tests(output bit ok);
        int    fd;
        string line;
        int    code, word, lk54, lkhd, rsy, frc, rdy, pulses, rsp, led;
        ok = 1'b1;
        fd = $fopen("testbench/console_ctrl_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/console_ctrl_tests.txt");
            ok = 1'b0;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            if (n_tests == MAX_TESTS || $sscanf(line, "%h %h %d %d %d %d %d %d %h %d",
                    code, word, lk54, lkhd, rsy, frc, rdy, pulses, rsp, led) != 10) begin
                $display("test file has a malformed line or too many lines: %s", line);
                ok = 1'b0;
                break;
            end
            tests[n_tests] = '{code, word, lk54, lkhd, rsy, frc, rdy, pulses, rsp, led};
            n_tests++;
        end
        $fclose(fd);
        if (n_tests == 0) begin
            $display("test file holds no tests");
            ok = 1'b0;
        end
    endtask

    // levels held for two cycles
    task automatic drive_status(input bit lk54, input bit lkhd, input bit rsy);
        @(posedge control_clock);
        pll54_locked    <= lk54;
        pll_hdmi_locked <= lkhd;
        resync          <= rsy;
        @(posedge control_clock);
    endtask

    // one lock loss on each pll and one resync per pulse
    task automatic pulse_events(input int n);
        repeat (n) begin
            drive_status(1'b1, 1'b1, 1'b0);
            drive_status(1'b0, 1'b0, 1'b1);
        end
    endtask

    task automatic request(input logic [15:0] word);
        @(posedge control_clock);
        cmd_word <= word;
        cmd_req  <= 1'b1;
        @(negedge control_clock);
        while (!cmd_ack) @(negedge control_clock);
    endtask

    task automatic release_req();
        @(posedge control_clock);
        cmd_req <= 1'b0;
        @(negedge control_clock);
        while (cmd_ack) @(negedge control_clock);
    endtask

    ////////////////////////////////////////////////////////////
    // one test line

    task automatic run_test(input int idx);
        logic [15:0] word;
        logic [3:0]  op;
        bit          hold_test;
        bit          console_line;
        bit          led_follows;
        string       held_name;
        string       other_name;
        word         = 16'(tests[idx][F_WORD]);
        op           = word[15:12];
        test_ok      = 1'b1;
        hold_test    = (op == OP_CONSOLE_RESET) || (op == OP_OPT_RESET);
        console_line = (op == OP_CONSOLE_RESET);
        if (console_line) begin
            held_name   = "console_nreset";
            other_name  = "opt_nreset";
            led_follows = (led_mode == LED_CONSOLE_RESET);
        end else begin
            held_name   = "opt_nreset";
            other_name  = "console_nreset";
            led_follows = (led_mode == LED_OPT_RESET) || (led_mode == 2'd3);
        end

        pulse_events(tests[idx][F_PULSES]);
        @(posedge control_clock);
        force_generate <= 1'(tests[idx][F_FORCE]);
        hdmi_ready     <= 1'(tests[idx][F_READY]);
        drive_status(1'(tests[idx][F_LK54]), 1'(tests[idx][F_LKHD]),
                     1'(tests[idx][F_RESYNC]));
        @(posedge control_clock);

        request(word);
        check("rsp_data", 32'(rsp_data), 32'(tests[idx][F_RSP]));
        if (hold_test) begin
            check(held_name, 32'(line_level(console_line)), 32'd0);
            check(other_name, 32'(line_level(!console_line)), 32'd1);
            @(negedge control_clock);
            if (led_follows) begin
                check("status_led", 32'(status_led), 32'd0);
            end
        end
        release_req();
        if (op == OP_SET_LED_MODE) begin
            led_mode = word[11:10];
        end

        if (hold_test) begin
            repeat (HOLD_CYCLES + 5) begin
                @(negedge control_clock);
                check(other_name, 32'(line_level(!console_line)), 32'd1);
            end
            check(held_name, 32'(line_level(console_line)), 32'd1);
        end else begin
            @(negedge control_clock);
        end
        check("status_led", 32'(status_led), 32'(tests[idx][F_LED]));

        if (!test_ok) begin
            failed_tests++;
        end
        $display("test %02h %s", tests[idx][F_CODE], test_ok ? "ok" : "failed");
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        bit loaded_ok;
        reset_dc        = 1'b1;
        cmd_req         = 1'b0;
        cmd_word        = '0;
        pll54_locked    = 1'b1;
        pll_hdmi_locked = 1'b0;
        resync          = 1'b0;
        force_generate  = 1'b0;
        hdmi_ready      = 1'b0;
        n_tests         = 0;
        mismatches      = 0;
        failed_tests    = 0;
        led_mode        = LED_INDICATOR;

        load_tests(loaded_ok);
        loaded = 1'b1;
        if (!loaded_ok) begin
            $display("Result: FAILED");
            $finish;
        end else begin
            repeat (2) @(posedge control_clock);
            reset_dc <= 1'b0;
            for (int i = 0; i < n_tests; i++) begin
                run_test(i);
            end
            $display("%0d tests run, %0d failed, %0d mismatches",
                     n_tests, failed_tests, mismatches);
            if (failed_tests == 0) begin
                $display("Result: PASSED");
            end else begin
                $display("Result: FAILED");
            end
            $finish;
        end
    end

endmodule

/* console_ctrl_top.f */
src/console_ctrl_pkg.sv
src/led_glow.sv
src/command_decode.sv
src/reset_execute.sv
src/event_counters.sv
src/status_result.sv
src/console_ctrl_top.sv
testbench/console_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the console controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module console_ctrl_tb \
    -f console_ctrl_top.f -o console_ctrl_sim

sim_out=$(./obj_dir/console_ctrl_sim)
echo "$sim_out"
if echo "$sim_out" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1

/* testbench/console_ctrl_tests.txt */
# code word pll54 pll_hdmi resync force ready pulses rsp led
# word and rsp in hex, levels 0/1, pulses decimal, led is status_led after the test
01 4000 1 0 0 0 0 0 00 1
02 4400 1 0 0 0 0 0 00 1
03 4800 1 0 0 0 0 0 00 1
04 4000 1 1 0 0 1 3 03 0
05 4100 1 1 0 0 1 0 00 0
06 4300 1 1 0 0 1 0 00 0
07 4400 1 1 0 0 1 0 03 0
08 4800 1 1 0 0 1 0 03 0
09 4800 1 1 0 0 1 2 05 0
0a 4c00 1 1 0 0 1 0 00 0
0b 1000 1 1 0 0 1 0 00 0
0c 3400 1 1 0 0 1 0 00 1
0d 2000 1 1 0 0 1 0 00 1
0e 3c00 1 1 0 0 1 0 00 1
0f 2000 1 1 0 0 1 0 00 1
10 3800 1 1 0 0 1 0 00 1
11 1000 1 1 0 0 1 0 00 1
12 0000 1 1 0 0 1 0 ff 1
13 f123 1 1 0 0 1 0 ff 1
14 3000 1 1 0 0 1 0 00 0
15 3000 1 0 0 0 0 0 00 1
16 4400 1 0 0 0 0 0 06 1
17 4000 1 0 0 0 0 0 05 1
